// File: Makefile
# Verilator build and run for the execute stage

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ex_stage.f
src/ex_pkg.sv
src/ex_operand_select.sv
src/ex_alu32.sv
src/ex_mmx_alu.sv
src/ex_functional_unit.sv
src/ex_result_select.sv
src/ex_stage.sv
test/ex_stage_tb.sv

// File: src/ex_alu32.sv
`timescale 1ns/1ps

module ex_alu32 (
	input  ex_pkg::aluk_e  aluk,
	input  ex_pkg::dsize_e dsize,
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	input  logic           cf_in,
	input  logic           af_in,
	output logic [31:0]    result,
	output logic [31:0]    flags
);
	import ex_pkg::*;

	logic [31:0] mask;
	logic [4:0]  top;
	logic        adc_cin;
	logic [32:0] add_w;
	logic [32:0] sub_w;
	logic        carry_add;
	logic        cf;

	// operand width, qword falls back to dword
	always_comb begin
		case (dsize)
			DSIZE_BYTE: begin
				mask = 32'h0000_00ff;
				top  = 5'd7;
			end
			DSIZE_WORD: begin
				mask = 32'h0000_ffff;
				top  = 5'd15;
			end
			default: begin
				mask = 32'hffff_ffff;
				top  = 5'd31;
			end
		endcase
	end

	assign adc_cin = (aluk == ALUK_ADC) ? cf_in : 1'b0;

	// masked copies give carry and borrow at the chosen width
	assign add_w = {1'b0, a & mask} + {1'b0, b & mask} + 33'(adc_cin);
	assign sub_w = {1'b0, a & mask} - {1'b0, b & mask};

	always_comb begin
		case (dsize)
			DSIZE_BYTE: carry_add = add_w[8];
			DSIZE_WORD: carry_add = add_w[16];
			default:    carry_add = add_w[32];
		endcase
	end

	always_comb begin
		result = 32'd0;
		cf     = 1'b0;
		case (aluk)
			ALUK_ADD: begin
				result = a + b;
				cf     = carry_add;
			end
			ALUK_ADC: begin
				result = a + b + 32'(cf_in);
				cf     = carry_add;
			end
			ALUK_SUB: begin
				result = a - b;
				// borrow fills the upper bits of the masked difference
				cf     = sub_w[32];
			end
			ALUK_OR:     result = a | b;
			ALUK_AND:    result = a & b;
			ALUK_XOR:    result = a ^ b;
			ALUK_NOT:    result = ~a;
			ALUK_PASS_B: result = b;
			default:     result = 32'd0;
		endcase
	end

	always_comb begin
		flags          = 32'd0;
		flags[FLAG_CF] = cf;
		flags[FLAG_AF] = af_in;
		flags[FLAG_ZF] = ((result & mask) == 32'd0);
		flags[FLAG_SF] = result[top];
	end

endmodule

// File: src/ex_functional_unit.sv
`timescale 1ns/1ps

module ex_functional_unit (
	input  ex_pkg::ex_ctrl_t     ctrl,
	input  ex_pkg::ex_operands_t ops,
	input  logic [31:0]          b_eff,
	input  logic [31:0]          count_eff,
	input  logic [31:0]          flags_fwd,
	output ex_pkg::ex_fu_out_t   fu
);
	import ex_pkg::*;

	logic [31:0] alu_result;
	logic [31:0] alu_flags;
	logic [63:0] mm_result;
	logic [4:0]  shamt;
	logic [32:0] shl_w;
	logic [32:0] shr_w;
	logic        shift_right;
	logic [31:0] shift_res;
	logic [31:0] shift_flags;
	logic [31:0] step;

	ex_alu32 alu32_inst (
		.aluk   (ctrl.aluk),
		.dsize  (ctrl.dsize),
		.a      (ops.a),
		.b      (b_eff),
		.cf_in  (flags_fwd[FLAG_CF]),
		.af_in  (flags_fwd[FLAG_AF]),
		.result (alu_result),
		.flags  (alu_flags)
	);

	ex_mmx_alu mmx_alu_inst (
		.dsize     (ctrl.dsize),
		.mm_a      (ops.mm_a),
		.mm_b      (ops.mm_b),
		.mm_result (mm_result)
	);

	// ------------------------------
	// shifter
	// ------------------------------

	// extra bit catches the last bit shifted out
	assign shamt       = ops.b[4:0];
	assign shift_right = ctrl.aluk[0];
	assign shl_w       = {1'b0, ops.a} << shamt;
	assign shr_w       = {ops.a, 1'b0} >> shamt;
	assign shift_res   = shift_right ? shr_w[32:1] : shl_w[31:0];

	always_comb begin
		shift_flags          = flags_fwd;
		shift_flags[FLAG_CF] = shift_right ? shr_w[0] : shl_w[32];
		shift_flags[FLAG_ZF] = (shift_res == 32'd0);
		shift_flags[FLAG_SF] = shift_res[31];
	end

	// ------------------------------
	// pointer and count arithmetic
	// ------------------------------

	// 1, 2, 4 or 8 bytes
	assign step = 32'd1 << ctrl.dsize;

	always_comb begin
		fu.alu_result      = alu_result;
		fu.alu_flags       = alu_flags;
		fu.shift_result    = shift_res;
		fu.shift_flags     = shift_flags;
		fu.count_minus_one = count_eff - 32'd1;
		fu.sp_pop          = ops.c + step;
		// df set walks the strings downward
		fu.cmps_pointer    = flags_fwd[FLAG_DF] ? (b_eff - step) : (b_eff + step);
		fu.mm_result       = mm_result;
	end

endmodule

// File: src/ex_mmx_alu.sv
`timescale 1ns/1ps

module ex_mmx_alu (
	input  ex_pkg::dsize_e dsize,
	input  logic [63:0]    mm_a,
	input  logic [63:0]    mm_b,
	output logic [63:0]    mm_result
);
	import ex_pkg::*;

	mm_word_u op_a;
	mm_word_u op_b;
	mm_word_u sum8;
	mm_word_u sum16;

	assign op_a = mm_a;
	assign op_b = mm_b;

	// byte lanes, carries dropped at each lane edge
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			sum8.lane8[i] = op_a.lane8[i] + op_b.lane8[i];
		end
	end

	// 16-bit lanes
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			sum16.lane16[i] = op_a.lane16[i] + op_b.lane16[i];
		end
	end

	// anything wider than a byte runs as word lanes
	assign mm_result = (dsize == DSIZE_BYTE) ? sum8 : sum16;

endmodule

// File: src/ex_operand_select.sv
`timescale 1ns/1ps

module ex_operand_select (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ld_en,
	input  logic                 valid,
	input  ex_pkg::ex_ctrl_t     ctrl,
	input  ex_pkg::ex_operands_t ops,
	input  logic [31:0]          count_fwd,
	output logic [31:0]          b_eff,
	output logic [31:0]          count_eff
);
	import ex_pkg::*;

	// first cmps uop leaves its a operand here
	logic [31:0] cmps_temp;
	logic        cmps_load;

	// only load when the uop actually moves into wb
	assign cmps_load = ctrl.is_cmps_first && valid && ld_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			cmps_temp <= 32'd0;
		end else if (cmps_load) begin
			cmps_temp <= ops.a;
		end
	end

	// second uop compares against the saved operand
	assign b_eff = ctrl.is_cmps_second ? cmps_temp : ops.b;

	// repne steady state uses the forwarded count
	assign count_eff = ctrl.repne_steady ? count_fwd : ops.c;

	// the two halves of a cmps never arrive as one uop
	a_cmps_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		valid |-> !(ctrl.is_cmps_first && ctrl.is_cmps_second)
	);

endmodule

// File: src/ex_pkg.sv
package ex_pkg;

	// ------------------------------
	// operation and size encodings
	// ------------------------------

	// bit 0 doubles as shift direction, 1 is logical right
	typedef enum logic [2:0] {
		ALUK_ADD    = 3'd0,
		ALUK_OR     = 3'd1,
		ALUK_ADC    = 3'd2,
		ALUK_AND    = 3'd3,
		ALUK_SUB    = 3'd4,
		ALUK_XOR    = 3'd5,
		ALUK_NOT    = 3'd6,
		ALUK_PASS_B = 3'd7
	} aluk_e;

	// step is 1 << size
	typedef enum logic [1:0] {
		DSIZE_BYTE  = 2'd0,
		DSIZE_WORD  = 2'd1,
		DSIZE_DWORD = 2'd2,
		DSIZE_QWORD = 2'd3
	} dsize_e;

	// eflags bit positions
	localparam int FLAG_CF = 0;
	localparam int FLAG_AF = 4;
	localparam int FLAG_ZF = 6;
	localparam int FLAG_SF = 7;
	localparam int FLAG_DF = 10;

	// ------------------------------
	// bundles
	// ------------------------------

	typedef struct packed {
		aluk_e  aluk;
		dsize_e dsize;
		logic   is_alu32;
		logic   is_alu32_flags;
		logic   is_cmps_first;
		logic   is_cmps_second;
		logic   repne_steady;
		logic   is_repne;
		logic   is_cmpxchg;
		logic   is_xchg;
		logic   pass_a;
		logic   alu_to_b;
		logic   mux_sp_pop;
		logic   mux_cmps_pointer;
		logic   ld_gpr1;
		logic   ld_gpr2;
		logic   ld_gpr3;
		logic   ld_seg;
		logic   ld_mm;
		logic   dcache_write;
	} ex_ctrl_t;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [63:0] mm_a;
		logic [63:0] mm_b;
	} ex_operands_t;

	// mmx register seen as byte lanes or 16-bit lanes
	typedef union packed {
		logic [7:0][7:0]  lane8;
		logic [3:0][15:0] lane16;
	} mm_word_u;

	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] alu_flags;
		logic [31:0] shift_result;
		logic [31:0] shift_flags;
		logic [31:0] count_minus_one;
		logic [31:0] sp_pop;
		logic [31:0] cmps_pointer;
		logic [63:0] mm_result;
	} ex_fu_out_t;

	typedef struct packed {
		logic [31:0] result_a;
		logic [31:0] result_b;
		logic [31:0] result_c;
		logic [31:0] flags;
		logic [63:0] result_mm;
		logic        ld_gpr1;
		logic        ld_gpr2;
		logic        ld_gpr3;
		logic        ld_seg;
		logic        ld_mm;
		logic        dcache_write;
	} wb_bundle_t;

endpackage

// File: src/ex_result_select.sv
`timescale 1ns/1ps

module ex_result_select (
	input  ex_pkg::ex_ctrl_t     ctrl,
	input  ex_pkg::ex_operands_t ops,
	input  logic                 valid,
	input  ex_pkg::ex_fu_out_t   fu,
	output ex_pkg::wb_bundle_t   wb_next
);
	import ex_pkg::*;

	logic zf;
	logic ld_gpr1_x;
	logic ld_gpr2_x;
	logic dcache_write_x;

	assign zf = fu.alu_flags[FLAG_ZF];

	// cmpxchg writes the destination only on a match, else loads the accumulator
	always_comb begin
		if (ctrl.is_cmpxchg) begin
			ld_gpr1_x      = ctrl.ld_gpr1 && zf;
			dcache_write_x = ctrl.dcache_write && zf;
			ld_gpr2_x      = !zf;
		end else begin
			ld_gpr1_x      = ctrl.ld_gpr1;
			dcache_write_x = ctrl.dcache_write;
			ld_gpr2_x      = ctrl.ld_gpr2;
		end
	end

	always_comb begin
		// result a, first match wins
		if (ctrl.is_alu32)                             wb_next.result_a = fu.alu_result;
		else if (ctrl.is_cmps_first || ctrl.is_xchg)   wb_next.result_a = ops.b;
		else if (ctrl.pass_a)                          wb_next.result_a = ops.a;
		else if (ctrl.is_cmpxchg)                      wb_next.result_a = ops.c;
		else                                           wb_next.result_a = fu.shift_result;

		// result b
		if (ctrl.mux_cmps_pointer)                     wb_next.result_b = fu.cmps_pointer;
		else if (ctrl.alu_to_b)                        wb_next.result_b = fu.alu_result;
		else if (ctrl.is_cmpxchg || ctrl.is_xchg)      wb_next.result_b = ops.a;
		else                                           wb_next.result_b = ops.b;

		// result c, count on the second cmps uop
		if (ctrl.is_cmps_second)                       wb_next.result_c = fu.count_minus_one;
		else if (ctrl.mux_sp_pop)                      wb_next.result_c = fu.sp_pop;
		else                                           wb_next.result_c = ops.c;

		wb_next.flags     = ctrl.is_alu32_flags ? fu.alu_flags : fu.shift_flags;
		wb_next.result_mm = fu.mm_result;

		// nothing writes back from a bubble
		wb_next.ld_gpr1      = ld_gpr1_x && valid;
		wb_next.ld_gpr2      = ld_gpr2_x && valid;
		wb_next.ld_gpr3      = ctrl.ld_gpr3 && valid;
		wb_next.ld_seg       = ctrl.ld_seg && valid;
		wb_next.ld_mm        = ctrl.ld_mm && valid;
		wb_next.dcache_write = dcache_write_x && valid;
	end

endmodule

// File: src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ex_v,
	input  ex_pkg::ex_ctrl_t     ex_ctrl,
	input  ex_pkg::ex_operands_t ex_ops,
	input  logic [31:0]          count_fwd,
	input  logic [31:0]          flags_fwd,
	input  logic                 repne_terminate,
	input  logic                 wb_stall,
	output logic                 ex_ld_latch,
	output logic                 wb_v,
	output ex_pkg::wb_bundle_t   wb
);
	import ex_pkg::*;

	logic [31:0] b_eff;
	logic [31:0] count_eff;
	ex_fu_out_t  fu;
	wb_bundle_t  wb_next;
	logic        wb_v_next;

	// uop is consumed whenever wb is not stalled
	assign ex_ld_latch = !wb_stall;

	// repne iterations only retire on the terminating pass
	assign wb_v_next = ex_v && (!ex_ctrl.is_repne || repne_terminate);

	ex_operand_select operand_select_inst (
		.clk       (clk),
		.rst       (rst),
		.ld_en     (ex_ld_latch),
		.valid     (ex_v),
		.ctrl      (ex_ctrl),
		.ops       (ex_ops),
		.count_fwd (count_fwd),
		.b_eff     (b_eff),
		.count_eff (count_eff)
	);

	ex_functional_unit functional_unit_inst (
		.ctrl      (ex_ctrl),
		.ops       (ex_ops),
		.b_eff     (b_eff),
		.count_eff (count_eff),
		.flags_fwd (flags_fwd),
		.fu        (fu)
	);

	ex_result_select result_select_inst (
		.ctrl    (ex_ctrl),
		.ops     (ex_ops),
		.valid   (wb_v_next),
		.fu      (fu),
		.wb_next (wb_next)
	);

	// ------------------------------
	// writeback latch
	// ------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_v            <= 1'b0;
			wb.ld_gpr1      <= 1'b0;
			wb.ld_gpr2      <= 1'b0;
			wb.ld_gpr3      <= 1'b0;
			wb.ld_seg       <= 1'b0;
			wb.ld_mm        <= 1'b0;
			wb.dcache_write <= 1'b0;
		end else if (ex_ld_latch) begin
			wb_v <= wb_v_next;
			wb   <= wb_next;
		end
	end

	a_wb_enables_valid: assert property (
		@(posedge clk) disable iff (rst)
		!wb_v |-> !(wb.ld_gpr1 || wb.ld_gpr2 || wb.ld_gpr3 ||
			wb.ld_seg || wb.ld_mm || wb.dcache_write)
	);

endmodule

// File: test/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;
	import ex_pkg::*;

	localparam int WAIT_LIMIT = 50;

	logic         clk;
	logic         rst;
	logic         ex_v;
	ex_ctrl_t     ex_ctrl;
	ex_operands_t ex_ops;
	logic [31:0]  count_fwd;
	logic [31:0]  flags_fwd;
	logic         repne_terminate;
	logic         wb_stall;
	logic         ex_ld_latch;
	logic         wb_v;
	wb_bundle_t   wb;

	int value_errors;
	int timeout_errors;

	ex_stage ex_stage_inst (
		.clk             (clk),
		.rst             (rst),
		.ex_v            (ex_v),
		.ex_ctrl         (ex_ctrl),
		.ex_ops          (ex_ops),
		.count_fwd       (count_fwd),
		.flags_fwd       (flags_fwd),
		.repne_terminate (repne_terminate),
		.wb_stall        (wb_stall),
		.ex_ld_latch     (ex_ld_latch),
		.wb_v            (wb_v),
		.wb              (wb)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic check_valid(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// only cf, zf and sf are compared
	task automatic check_flags(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		logic [31:0] care;
		care          = '0;
		care[FLAG_CF] = 1'b1;
		care[FLAG_ZF] = 1'b1;
		care[FLAG_SF] = 1'b1;
		if (((got ^ exp) & care) !== 32'd0) begin
			value_errors++;
			$display("FAIL %0t: %s flags got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_wb(input string what, input wb_bundle_t got, input wb_bundle_t exp,
			input wb_bundle_t care);
		if (((got ^ exp) & care) !== '0) begin
			value_errors++;
			$display("FAIL %0t: %s wb got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// reference model and drivers
	// ------------------------------

	function automatic void expect_alu(input aluk_e op, input int size, input logic [31:0] a,
			input logic [31:0] b, input logic cin, output logic [31:0] res,
			output logic [31:0] flg);
		int          w;
		logic [31:0] m;
		logic [32:0] sum;
		w   = (size >= 2) ? 32 : (8 << size);
		m   = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
		sum = {1'b0, a & m} + {1'b0, b & m};
		if (op == ALUK_ADC)
			sum = sum + {32'd0, cin};
		res = '0;
		flg = '0;
		case (op)
			ALUK_ADD: begin
				res          = a + b;
				flg[FLAG_CF] = sum[w];
			end
			ALUK_ADC: begin
				res          = a + b + {31'd0, cin};
				flg[FLAG_CF] = sum[w];
			end
			ALUK_SUB: begin
				res          = a - b;
				flg[FLAG_CF] = (a & m) < (b & m);
			end
			ALUK_AND: res = a & b;
			ALUK_OR:  res = a | b;
			ALUK_XOR: res = a ^ b;
			default:  res = '0;
		endcase
		flg[FLAG_ZF] = ((res & m) == 32'd0);
		flg[FLAG_SF] = res[w-1];
	endfunction

	task automatic drive_idle();
		ex_v            <= 1'b0;
		ex_ctrl         <= '0;
		repne_terminate <= 1'b0;
	endtask

	// one uop for one edge, once the stage accepts
	task automatic issue_uop(input ex_ctrl_t c, input ex_operands_t o, input logic [31:0] cnt,
			input logic [31:0] flg, input logic term);
		int n;
		n = 0;
		while (!ex_ld_latch && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!ex_ld_latch) begin
			timeout_errors++;
			$display("timeout: the stage never accepted a uop at %0t", $time);
		end
		@(posedge clk);
		ex_v            <= 1'b1;
		ex_ctrl         <= c;
		ex_ops          <= o;
		count_fwd       <= cnt;
		flags_fwd       <= flg;
		repne_terminate <= term;
		@(posedge clk);
		drive_idle();
	endtask

	task automatic wait_wb(input string what, output wb_bundle_t got);
		int n;
		n = 0;
		@(negedge clk);
		while (!wb_v && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!wb_v) begin
			timeout_errors++;
			$display("timeout: %s never reached writeback", what);
		end
		got = wb;
	endtask

	task automatic run_uop(input ex_ctrl_t c, input ex_operands_t o, input logic [31:0] cnt,
			input logic [31:0] flg, input string what, output wb_bundle_t got);
		issue_uop(c, o, cnt, flg, 1'b0);
		wait_wb(what, got);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------

	task automatic test_alu();
		aluk_e        op_list [6];
		ex_ctrl_t     c;
		ex_operands_t o;
		wb_bundle_t   got;
		wb_bundle_t   exp;
		wb_bundle_t   care;
		logic [31:0]  res;
		logic [31:0]  flg;
		logic [31:0]  exp_flags;
		logic         cin;
		string        what;
		op_list = '{ALUK_ADD, ALUK_ADC, ALUK_SUB, ALUK_AND, ALUK_OR, ALUK_XOR};
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < 6; k++) begin
				// second pass uses b equal to a so zf gets exercised
				for (int r = 0; r < 2; r++) begin
					c                = '0;
					c.aluk           = op_list[k];
					c.dsize          = dsize_e'(s);
					c.is_alu32       = 1'b1;
					c.is_alu32_flags = 1'b1;
					c.ld_gpr1        = 1'b1;
					o                = '0;
					o.a              = $urandom;
					o.b              = (r == 1) ? o.a : $urandom;
					cin              = 1'($urandom & 1);
					flg              = '0;
					flg[FLAG_CF]     = cin;
					what             = $sformatf("alu op %0d size %0d", k, s);
					expect_alu(op_list[k], s, o.a, o.b, cin, res, exp_flags);
					run_uop(c, o, 32'd0, flg, what, got);
					exp           = '0;
					exp.result_a  = res;
					exp.ld_gpr1   = 1'b1;
					care          = '0;
					care.result_a = '1;
					care.ld_gpr1  = 1'b1;
					care.ld_gpr2  = 1'b1;
					check_wb(what, got, exp, care);
					check_flags(what, got.flags, exp_flags);
				end
			end
		end
	endtask

	task automatic test_cmpxchg();
		ex_ctrl_t     c;
		ex_operands_t o;
		wb_bundle_t   got;
		wb_bundle_t   exp;
		wb_bundle_t   care;
		logic         equal;
		for (int r = 0; r < 2; r++) begin
			equal          = (r == 0);
			c              = '0;
			c.aluk         = ALUK_SUB;
			c.dsize        = DSIZE_DWORD;
			c.is_cmpxchg   = 1'b1;
			c.ld_gpr1      = 1'b1;
			c.dcache_write = 1'b1;
			o              = '0;
			o.a            = $urandom;
			o.b            = equal ? o.a : (o.a ^ 32'h0000_0100);
			o.c            = $urandom;
			run_uop(c, o, 32'd0, 32'd0, "cmpxchg", got);
			exp              = '0;
			exp.result_a     = o.c;
			exp.result_b     = o.a;
			exp.ld_gpr1      = equal;
			exp.dcache_write = equal;
			exp.ld_gpr2      = !equal;
			care              = '0;
			care.result_a     = '1;
			care.result_b     = '1;
			care.ld_gpr1      = 1'b1;
			care.ld_gpr2      = 1'b1;
			care.ld_gpr3      = 1'b1;
			care.ld_seg       = 1'b1;
			care.ld_mm        = 1'b1;
			care.dcache_write = 1'b1;
			check_wb($sformatf("cmpxchg equal %0b", equal), got, exp, care);
		end
	endtask

	task automatic test_cmps();
		ex_ctrl_t     c;
		ex_operands_t o;
		wb_bundle_t   got;
		wb_bundle_t   exp;
		wb_bundle_t   care;
		logic [31:0]  stored;
		logic [31:0]  step;
		logic [31:0]  cnt;
		logic [31:0]  flg;
		for (int s = 0; s < 4; s++) begin
			for (int df = 0; df < 2; df++) begin
				c               = '0;
				c.dsize         = dsize_e'(s);
				c.is_cmps_first = 1'b1;
				c.ld_gpr1       = 1'b1;
				o               = '0;
				o.a             = $urandom;
				o.b             = $urandom;
				stored          = o.a;
				run_uop(c, o, 32'd0, 32'd0, "cmps first", got);
				exp           = '0;
				exp.result_a  = o.b;
				care          = '0;
				care.result_a = '1;
				check_wb("cmps first", got, exp, care);

				// df and repne_steady switch together here
				c                  = '0;
				c.aluk             = ALUK_SUB;
				c.dsize            = dsize_e'(s);
				c.is_cmps_second   = 1'b1;
				c.mux_cmps_pointer = 1'b1;
				c.repne_steady     = 1'(df);
				c.ld_gpr2          = 1'b1;
				c.ld_gpr3          = 1'b1;
				o.a                = $urandom;
				o.b                = $urandom;
				o.c                = $urandom;
				cnt                = $urandom;
				flg                = '0;
				flg[FLAG_DF]       = 1'(df);
				step               = 32'd1 << s;
				run_uop(c, o, cnt, flg, "cmps second", got);
				exp.result_b  = (df == 1) ? (stored - step) : (stored + step);
				exp.result_c  = ((df == 1) ? cnt : o.c) - 32'd1;
				care          = '0;
				care.result_b = '1;
				care.result_c = '1;
				check_wb($sformatf("cmps second size %0d df %0d", s, df), got, exp, care);
			end
		end
	endtask

	task automatic test_pop_shift();
		ex_ctrl_t     c;
		ex_operands_t o;
		wb_bundle_t   got;
		wb_bundle_t   exp;
		wb_bundle_t   care;
		logic [31:0]  exp_flags;
		int           n;
		for (int s = 0; s < 4; s++) begin
			c            = '0;
			c.dsize      = dsize_e'(s);
			c.mux_sp_pop = 1'b1;
			c.ld_gpr3    = 1'b1;
			o            = '0;
			o.c          = $urandom;
			run_uop(c, o, 32'd0, 32'd0, "pop", got);
			exp           = '0;
			exp.result_c  = o.c + (32'd1 << s);
			exp.ld_gpr3   = 1'b1;
			care          = '0;
			care.result_c = '1;
			care.ld_gpr3  = 1'b1;
			check_wb($sformatf("pop size %0d", s), got, exp, care);
		end
		for (int dir = 0; dir < 2; dir++) begin
			for (int r = 0; r < 4; r++) begin
				c         = '0;
				c.aluk    = (dir == 1) ? ALUK_OR : ALUK_ADD;
				c.ld_gpr1 = 1'b1;
				o         = '0;
				o.a       = (r == 3) ? 32'd0 : $urandom;
				n         = 1 + int'($urandom % 31);
				o.b       = ($urandom & 32'hffff_ffe0) | 32'(n);
				run_uop(c, o, 32'd0, 32'd0, "shift", got);
				exp                = '0;
				exp.result_a       = (dir == 1) ? (o.a >> n) : (o.a << n);
				exp_flags          = '0;
				exp_flags[FLAG_CF] = (dir == 1) ? o.a[n-1] : o.a[32-n];
				exp_flags[FLAG_ZF] = (exp.result_a == 32'd0);
				exp_flags[FLAG_SF] = exp.result_a[31];
				care               = '0;
				care.result_a      = '1;
				check_wb($sformatf("shift dir %0d by %0d", dir, n), got, exp, care);
				check_flags($sformatf("shift dir %0d by %0d", dir, n), got.flags, exp_flags);
			end
		end
	endtask

	task automatic test_mmx();
		ex_ctrl_t     c;
		ex_operands_t o;
		wb_bundle_t   got;
		wb_bundle_t   exp;
		wb_bundle_t   care;
		for (int s = 0; s < 2; s++) begin
			for (int r = 0; r < 3; r++) begin
				c       = '0;
				c.dsize = dsize_e'(s);
				c.ld_mm = 1'b1;
				o       = '0;
				o.mm_a  = {$urandom, $urandom};
				o.mm_b  = {$urandom, $urandom};
				run_uop(c, o, 32'd0, 32'd0, "mmx", got);
				exp = '0;
				if (s == 0) begin
					for (int i = 0; i < 8; i++)
						exp.result_mm[i*8 +: 8] = o.mm_a[i*8 +: 8] + o.mm_b[i*8 +: 8];
				end else begin
					for (int i = 0; i < 4; i++)
						exp.result_mm[i*16 +: 16] = o.mm_a[i*16 +: 16] + o.mm_b[i*16 +: 16];
				end
				exp.ld_mm      = 1'b1;
				care           = '0;
				care.result_mm = '1;
				care.ld_mm     = 1'b1;
				check_wb($sformatf("mmx size %0d", s), got, exp, care);
			end
		end
	endtask

	task automatic test_stall_bubble();
		ex_ctrl_t     c;
		ex_operands_t o;
		ex_operands_t o2;
		wb_bundle_t   got;
		wb_bundle_t   exp;
		wb_bundle_t   care;
		c             = '0;
		c.pass_a      = 1'b1;
		c.ld_gpr1     = 1'b1;
		o             = '0;
		o.a           = $urandom;
		o2            = o;
		o2.a          = ~o.a;
		exp           = '0;
		exp.result_a  = o.a;
		exp.ld_gpr1   = 1'b1;
		care          = '0;
		care.result_a = '1;
		care.ld_gpr1  = 1'b1;

		@(posedge clk);
		ex_v    <= 1'b1;
		ex_ctrl <= c;
		ex_ops  <= o;
		@(posedge clk);
		// first uop lands now, the second waits behind the stall
		wb_stall <= 1'b1;
		ex_ops   <= o2;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_valid("stall wb_v hold", wb_v, 1'b1);
			check_valid("stall ex_ld_latch", ex_ld_latch, 1'b0);
			check_wb("stall hold", wb, exp, care);
		end
		@(posedge clk);
		wb_stall <= 1'b0;
		@(posedge clk);
		drive_idle();
		@(negedge clk);
		exp.result_a = o2.a;
		check_valid("after stall wb_v", wb_v, 1'b1);
		check_valid("after stall ex_ld_latch", ex_ld_latch, 1'b1);
		check_wb("after stall", wb, exp, care);

		// ex_v low with a write request is a bubble
		@(posedge clk);
		ex_v    <= 1'b0;
		ex_ctrl <= c;
		@(posedge clk);
		drive_idle();
		@(negedge clk);
		check_valid("bubble wb_v", wb_v, 1'b0);
		check_valid("bubble ld_gpr1", wb.ld_gpr1, 1'b0);

		c.is_repne = 1'b1;
		issue_uop(c, o, 32'd0, 32'd0, 1'b0);
		@(negedge clk);
		check_valid("repne running wb_v", wb_v, 1'b0);
		issue_uop(c, o, 32'd0, 32'd0, 1'b1);
		wait_wb("repne terminate", got);
		exp.result_a = o.a;
		check_valid("repne terminate wb_v", wb_v, 1'b1);
		check_wb("repne terminate", got, exp, care);
	endtask

	initial begin
		void'($urandom(32'h35c2_d6b7));
		value_errors    = 0;
		timeout_errors  = 0;
		rst             = 1'b1;
		ex_v            = 1'b0;
		ex_ctrl         = '0;
		ex_ops          = '0;
		count_fwd       = '0;
		flags_fwd       = '0;
		repne_terminate = 1'b0;
		wb_stall        = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_valid("reset wb_v", wb_v, 1'b0);

		test_alu();
		test_cmpxchg();
		test_cmps();
		test_pop_shift();
		test_mmx();
		test_stall_bubble();

		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
